// File: verilog/glue_params.svh
`ifndef GLUE_PARAMS_SVH
`define GLUE_PARAMS_SVH

// cpu word address, byte address bits 23..1
`define GLUE_ADDR_W 23

// width of the vector bus back to the cpu
`define GLUE_DATA_W 8

// requesters sharing memory, one per clk_8
`define GLUE_SLOTS 4

// unacked strobe cycles before bus error
`define GLUE_TIMEOUT 63

// auto-vectors for ipl 4 and ipl 2
`define GLUE_VEC_VBI 8'h1c
`define GLUE_VEC_HBI 8'h1a

// io window bases, low 16 bits of $ffxxxx
`define GLUE_MMU_BASE 16'h8000
`define GLUE_VREG_BASE 16'h8200
`define GLUE_DMA_BASE 16'h8600
`define GLUE_PSG_BASE 16'h8800
`define GLUE_MFP_BASE 16'hfa00
`define GLUE_ACIA_BASE 16'hfc00

`endif

// File: verilog/bus_pkg.sv
package bus_pkg;

	// memory slot, owner of the ram in each clk_8
	typedef enum logic [1:0] {
		slot_video = 2'd0, // shifter fetch
		slot_host0 = 2'd1, // io controller up/download
		slot_cpu   = 2'd2, // 68000 access
		slot_host1 = 2'd3  // second host slot
	} bus_slot_e;

	// installed st ram, mirrors the config word
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4, // adds $400000-$7fffff
		mem_14m  = 3'd5  // adds up to $dfffff
	} mem_cfg_e;

	// coarse class of a cpu address
	typedef enum logic [2:0] {
		reg_none = 3'd0, // nothing there, times out
		reg_ram  = 3'd1,
		reg_rom  = 3'd2, // tos and cartridge
		reg_io   = 3'd3, // $ff0000 page
		reg_iack = 3'd4  // $fffff0, interrupt ack
	} region_e;

endpackage

// File: verilog/irq_pkg.sv
package irq_pkg;

	// 68000 ipl lines, active low
	// ipl[0] stays high on the st, so only even levels show up
	typedef enum logic [2:0] {
		ipl_none = 3'b111, // level 0
		ipl_hbi  = 3'b101, // level 2, horizontal blank
		ipl_vbi  = 3'b011, // level 4, vertical blank
		ipl_mfp  = 3'b001  // level 6, mfp 68901
	} ipl_e;

endpackage

// File: verilog/bus_slot.sv
`include "glue_params.svh"

// bus rotation
// video, host, cpu, host and around again, one slot per clk_8
module bus_slot (
	input  logic               clk_8,
	input  logic               pll_locked,
	output bus_pkg::bus_slot_e slot
);

	logic last_slot; // end of rotation

	assign last_slot = (slot == bus_pkg::bus_slot_e'(`GLUE_SLOTS - 1));

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= bus_pkg::slot_video; // video owns the first cycle
		end else if (last_slot) begin
			slot <= bus_pkg::slot_video; // wrap
		end else begin
			slot <= bus_pkg::bus_slot_e'(slot + 2'd1);
		end
	end

endmodule

// File: verilog/addr_decode.sv
`include "glue_params.svh"

// cpu address decode, sampled in the cpu slot, results one cycle later
module addr_decode (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	input  bus_pkg::bus_slot_e      slot,
	input  logic [`GLUE_ADDR_W-1:0] addr,    // word address, byte bits 23..1
	input  logic                    uds_n,
	input  logic                    lds_n,
	input  logic                    rw,      // high for read
	input  bus_pkg::mem_cfg_e       mem_cfg,
	output logic                    strobe,  // registered data strobe level
	output logic                    acked,   // one cycle, any acked decode
	output logic                    ram_oe_n,
	output logic                    ram_we_n,
	output logic                    mmu_sel,
	output logic                    vreg_sel,
	output logic                    dma_sel,
	output logic                    psg_sel,
	output logic                    mfp_sel,
	output logic                    acia_sel,
	output logic                    mfp_iack,
	output logic [2:0]              iack_level // 0 when no iack
);

	logic             data_strobe;
	logic             sample;
	logic             big_ram;   // 8M or 14M
	logic             ram_pg;
	logic             rom_pg;
	logic             io_pg;
	logic             iack_pg;
	bus_pkg::region_e region;
	logic [15:0]      io_off;    // byte offset inside $ff page
	logic             mmu_hit;
	logic             vreg_hit;
	logic             dma_hit;
	logic             psg_hit;
	logic             mfp_hit;
	logic             acia_hit;
	logic             io_cyc;
	logic             iack_cyc;
	logic             mem_ack;
	logic             dev_ack;
	logic             iack_ack;

	// window match, ignoring the low lsb bits
	function automatic logic win_hit(input logic [15:0] off, input logic [15:0] base,
			input int lsb);
		return (off >> lsb) == (base >> lsb);
	endfunction

	assign data_strobe = ~uds_n | ~lds_n; // either byte lane
	assign sample = (slot == bus_pkg::slot_cpu) && data_strobe;

	assign big_ram = (mem_cfg == bus_pkg::mem_8m) || (mem_cfg == bus_pkg::mem_14m);

	// first 4M always there
	assign ram_pg = (addr[22:21] == 2'b00) ||
		(big_ram && addr[22:21] == 2'b01) ||
		(mem_cfg == bus_pkg::mem_14m && (addr[22:21] == 2'b10 || addr[22:20] == 3'b110));

	// 256k tos at $e00000, 192k tos at $fc0000, cartridge at $fa0000
	assign rom_pg = (addr[22:17] == 6'b111000) ||
		(addr[22:16] == 7'b1111110) || (addr[22:15] == 8'hfe) ||
		(addr[22:16] == 7'b1111101);

	assign io_pg   = (addr[22:15] == 8'hff);
	assign iack_pg = (addr[22:3] == 20'hfffff); // inside io page, checked first

	always_comb begin
		region = bus_pkg::reg_none;
		if (iack_pg)
			region = bus_pkg::reg_iack;
		else if (io_pg)
			region = bus_pkg::reg_io;
		else if (ram_pg)
			region = bus_pkg::reg_ram;
		else if (rom_pg)
			region = bus_pkg::reg_rom;
	end

	assign io_off   = {addr[14:0], 1'b0};
	assign mmu_hit  = win_hit(io_off, `GLUE_MMU_BASE, 1);  // 2 bytes
	assign vreg_hit = win_hit(io_off, `GLUE_VREG_BASE, 7); // 128 bytes
	assign dma_hit  = win_hit(io_off, `GLUE_DMA_BASE, 4);  // 16 bytes
	assign psg_hit  = win_hit(io_off, `GLUE_PSG_BASE, 2);  // 4 bytes
	assign mfp_hit  = win_hit(io_off, `GLUE_MFP_BASE, 6);  // 64 bytes
	assign acia_hit = win_hit(io_off, `GLUE_ACIA_BASE, 3); // 8 bytes

	assign io_cyc   = sample && (region == bus_pkg::reg_io);
	assign iack_cyc = sample && (region == bus_pkg::reg_iack);

	// rom is read only, a write gets no dtack
	assign mem_ack = (region == bus_pkg::reg_ram) || (region == bus_pkg::reg_rom && rw);
	assign dev_ack = (region == bus_pkg::reg_io) &&
		(mmu_hit || vreg_hit || dma_hit || psg_hit || mfp_hit || acia_hit);
	// mfp, vbi and hbi levels only
	assign iack_ack = (region == bus_pkg::reg_iack) &&
		(addr[2:0] == 3'd6 || addr[2:0] == 3'd4 || addr[2:0] == 3'd2);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			strobe     <= 1'b0;
			acked      <= 1'b0;
			ram_oe_n   <= 1'b1;
			ram_we_n   <= 1'b1;
			mmu_sel    <= 1'b0;
			vreg_sel   <= 1'b0;
			dma_sel    <= 1'b0;
			psg_sel    <= 1'b0;
			mfp_sel    <= 1'b0;
			acia_sel   <= 1'b0;
			mfp_iack   <= 1'b0;
			iack_level <= 3'd0;
		end else begin
			strobe   <= data_strobe;  // every cycle, feeds the watchdog
			acked    <= sample && (mem_ack || dev_ack || iack_ack);
			ram_oe_n <= ~(sample && rw && mem_ack);
			ram_we_n <= ~(sample && !rw && region == bus_pkg::reg_ram);
			// selects drop again after one cycle
			mmu_sel  <= io_cyc && mmu_hit;
			vreg_sel <= io_cyc && vreg_hit;
			dma_sel  <= io_cyc && dma_hit;
			psg_sel  <= io_cyc && psg_hit;
			mfp_sel  <= io_cyc && mfp_hit;
			acia_sel <= io_cyc && acia_hit;
			mfp_iack <= iack_cyc && (addr[2:0] == 3'd6);
			iack_level <= iack_cyc ? addr[2:0] : 3'd0; // level from A3..A1
		end
	end

endmodule

// File: verilog/bus_ack.sv
`include "glue_params.svh"

// dtack and the bus error watchdog
module bus_ack (
	input  logic clk_8,
	input  logic pll_locked,
	input  logic strobe, // cpu data strobe level
	input  logic acked,  // decode acknowledged this cycle
	output logic dtack_n,
	output logic berr
);

	// six bits for a limit of 63
	localparam int cnt_w = $clog2(`GLUE_TIMEOUT + 1);
	localparam logic [cnt_w-1:0] cnt_max = cnt_w'(`GLUE_TIMEOUT);

	logic [cnt_w-1:0] dtack_timeout; // cycles without answer

	assign dtack_n = ~acked; // same cycle as the selects

	// tos probes for missing hardware and expects a fault here
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			dtack_timeout <= '0;
		end else if (!strobe || acked) begin
			dtack_timeout <= '0; // released or answered
		end else if (dtack_timeout != cnt_max) begin
			dtack_timeout <= dtack_timeout + 1'b1;
		end
	end

	assign berr = (dtack_timeout == cnt_max); // held until strobe goes

endmodule

// File: verilog/irq_ctrl.sv
`include "glue_params.svh"

// vbi and hbi from the sync edges, ipl encoder, auto-vectors
module irq_ctrl (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	input  logic                    vs,
	input  logic                    hs,
	input  logic                    mfp_irq,
	input  logic [2:0]              iack_level, // 0 when no ack
	output irq_pkg::ipl_e           ipl,
	output logic [`GLUE_DATA_W-1:0] vector
);

	// bit 0 is vertical, bit 1 horizontal
	logic [1:0] sync1;     // first sync stage
	logic [1:0] sync2;     // second sync stage
	logic [1:0] sync3;     // previous synced level
	logic [1:0] sync_edge; // one cycle per rising edge
	logic [1:0] pend;      // {hbi, vbi}
	logic [1:0] irq_ack;

	// an ack at its own level clears the request
	assign irq_ack = {iack_level == 3'd2, iack_level == 3'd4};

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync1     <= 2'b00;
			sync2     <= 2'b00;
			sync3     <= 2'b00;
			sync_edge <= 2'b00;
			pend      <= 2'b00;
		end else begin
			sync1     <= {hs, vs};
			sync2     <= sync1;
			sync3     <= sync2;
			sync_edge <= sync2 & ~sync3; // rising only
			// ack wins over a new edge in the same cycle
			pend      <= (pend | sync_edge) & ~irq_ack;
		end
	end

	// highest pending source, mfp first
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			ipl <= irq_pkg::ipl_none;
		end else if (mfp_irq) begin
			ipl <= irq_pkg::ipl_mfp; // level 6
		end else if (pend[0]) begin
			ipl <= irq_pkg::ipl_vbi; // level 4
		end else if (pend[1]) begin
			ipl <= irq_pkg::ipl_hbi; // level 2
		end else begin
			ipl <= irq_pkg::ipl_none;
		end
	end

	// levels 4 and 2 are autovectored on the st
	// the mfp supplies its own vector, so level 6 gives 0 here
	always_comb begin
		case (iack_level)
			3'd4:    vector = `GLUE_VEC_VBI;
			3'd2:    vector = `GLUE_VEC_HBI;
			default: vector = '0;
		endcase
	end

endmodule

// File: verilog/st_glue.sv
`include "glue_params.svh"

// st bus glue, slot, decode, ack and interrupts in a row
module st_glue (
	input  logic                    clk_8,
	input  logic                    pll_locked,
	// 68000 side
	input  logic [`GLUE_ADDR_W-1:0] addr,
	input  logic                    uds_n,
	input  logic                    lds_n,
	input  logic                    rw,
	input  bus_pkg::mem_cfg_e       mem_cfg,
	// interrupt sources
	input  logic                    vs,
	input  logic                    hs,
	input  logic                    mfp_irq,
	// memory
	output bus_pkg::bus_slot_e      slot,
	output logic                    ram_oe_n,
	output logic                    ram_we_n,
	// peripheral selects
	output logic                    mmu_sel,
	output logic                    vreg_sel,
	output logic                    dma_sel,
	output logic                    psg_sel,
	output logic                    mfp_sel,
	output logic                    acia_sel,
	output logic                    mfp_iack,
	// back to the cpu
	output logic                    dtack_n,
	output logic                    berr,
	output irq_pkg::ipl_e           ipl,
	output logic [`GLUE_DATA_W-1:0] vector
);

	logic       strobe;     // registered data strobe
	logic       acked;      // decode answered
	logic [2:0] iack_level; // acknowledged irq level

	bus_slot u_slot (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.slot       (slot)
	);

	addr_decode u_decode (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.slot       (slot),
		.addr       (addr),
		.uds_n      (uds_n),
		.lds_n      (lds_n),
		.rw         (rw),
		.mem_cfg    (mem_cfg),
		.strobe     (strobe),
		.acked      (acked),
		.ram_oe_n   (ram_oe_n),
		.ram_we_n   (ram_we_n),
		.mmu_sel    (mmu_sel),
		.vreg_sel   (vreg_sel),
		.dma_sel    (dma_sel),
		.psg_sel    (psg_sel),
		.mfp_sel    (mfp_sel),
		.acia_sel   (acia_sel),
		.mfp_iack   (mfp_iack),
		.iack_level (iack_level)
	);

	bus_ack u_ack (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.strobe     (strobe),
		.acked      (acked),
		.dtack_n    (dtack_n),
		.berr       (berr)
	);

	irq_ctrl u_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.vs         (vs),
		.hs         (hs),
		.mfp_irq    (mfp_irq),
		.iack_level (iack_level),
		.ipl        (ipl),
		.vector     (vector)
	);

endmodule

// File: dv/st_glue_properties.sv
`include "glue_params.svh"

// reference model of the glue rules, each output compared every clk_8
module st_glue_properties (
	input logic                    clk_8,
	input logic                    pll_locked,
	input logic [`GLUE_ADDR_W-1:0] addr,
	input logic                    uds_n,
	input logic                    lds_n,
	input logic                    rw,
	input bus_pkg::mem_cfg_e       mem_cfg,
	input logic                    vs,
	input logic                    hs,
	input logic                    mfp_irq,
	input bus_pkg::bus_slot_e      slot,
	input logic                    ram_oe_n,
	input logic                    ram_we_n,
	input logic                    mmu_sel,
	input logic                    vreg_sel,
	input logic                    dma_sel,
	input logic                    psg_sel,
	input logic                    mfp_sel,
	input logic                    acia_sel,
	input logic                    mfp_iack,
	input logic                    dtack_n,
	input logic                    berr,
	input irq_pkg::ipl_e           ipl,
	input logic [`GLUE_DATA_W-1:0] vector
);

	int          errors = 0; // failed checks so far
	logic [23:0] a;          // byte address
	logic [23:0] ram_top;    // first byte past ram
	logic        is_ram;
	logic        is_rom;
	logic        is_io;
	logic        is_iack;
	logic [6:0]  win;        // mmu vreg dma psg mfp acia, then level 6 iack
	logic        req;        // data strobe in the cpu slot
	logic        ack_due;
	logic [1:0]  e_slot;
	logic [2:0]  e_bus;      // dtack_n ram_oe_n ram_we_n
	logic        e_berr;
	logic [6:0]  e_sel;
	logic [2:0]  e_level;    // acked iack level, 0 if none
	logic        e_strobe;
	logic [5:0]  e_wait;     // strobe cycles with no dtack
	logic [3:0]  vs_h;       // newest sample in bit 0
	logic [3:0]  hs_h;
	logic [1:0]  e_pend;     // {hbi, vbi}
	logic [2:0]  e_ipl;
	logic [7:0]  e_vec;

	function automatic logic in_win(input logic [15:0] off, input logic [15:0] base,
			input logic [15:0] size);
		return off >= base && off - base < size;
	endfunction

	assign a       = {addr, 1'b0};
	assign req     = slot == bus_pkg::slot_cpu && !(uds_n && lds_n);
	assign ram_top = mem_cfg == bus_pkg::mem_14m ? 24'he00000 :
		mem_cfg == bus_pkg::mem_8m ? 24'h800000 : 24'h400000; // 4M for the small sizes
	assign is_iack = a >= 24'hfffff0;
	assign is_io   = a >= 24'hff0000 && !is_iack;
	assign is_ram  = a < ram_top;
	// tos 256k, then cartridge and tos 192k up to the io page
	assign is_rom  = (a >= 24'he00000 && a < 24'he40000) || (a >= 24'hfa0000 && a < 24'hff0000);

	assign win[6] = is_io && in_win(a[15:0], `GLUE_MMU_BASE, 16'd2);
	assign win[5] = is_io && in_win(a[15:0], `GLUE_VREG_BASE, 16'd128);
	assign win[4] = is_io && in_win(a[15:0], `GLUE_DMA_BASE, 16'd16);
	assign win[3] = is_io && in_win(a[15:0], `GLUE_PSG_BASE, 16'd4);
	assign win[2] = is_io && in_win(a[15:0], `GLUE_MFP_BASE, 16'd64);
	assign win[1] = is_io && in_win(a[15:0], `GLUE_ACIA_BASE, 16'd8);
	assign win[0] = is_iack && a[3:1] == 3'd6; // mfp iack

	assign ack_due = is_ram || (is_rom && rw) || win[6:1] != 6'd0 ||
		(is_iack && a[3:1] inside {3'd2, 3'd4, 3'd6});

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			e_slot   <= 2'd0;
			e_bus    <= 3'b111;
			e_sel    <= '0;
			e_level  <= 3'd0;
			e_strobe <= 1'b0;
			e_wait   <= '0;
			vs_h     <= '0;
			hs_h     <= '0;
			e_pend   <= '0;
			e_ipl    <= irq_pkg::ipl_none;
		end else begin
			e_slot   <= e_slot + 2'd1; // video host0 cpu host1
			e_bus[2] <= !(req && ack_due);
			e_bus[1] <= !(req && rw && (is_ram || is_rom));
			e_bus[0] <= !(req && !rw && is_ram);
			e_sel    <= req ? win : '0;
			e_level  <= (req && is_iack) ? a[3:1] : 3'd0;
			e_strobe <= !(uds_n && lds_n);
			if (!e_strobe || !e_bus[2])
				e_wait <= '0; // released or answered
			else if (e_wait != 6'(`GLUE_TIMEOUT))
				e_wait <= e_wait + 6'd1;
			vs_h <= {vs_h[2:0], vs};
			hs_h <= {hs_h[2:0], hs};
			// latch three edges after the rise, an ack at its level wins
			e_pend[0] <= (e_pend[0] | (vs_h[2] & ~vs_h[3])) & (e_level != 3'd4);
			e_pend[1] <= (e_pend[1] | (hs_h[2] & ~hs_h[3])) & (e_level != 3'd2);
			e_ipl <= mfp_irq ? irq_pkg::ipl_mfp : e_pend[0] ? irq_pkg::ipl_vbi :
				e_pend[1] ? irq_pkg::ipl_hbi : irq_pkg::ipl_none;
		end
	end

	assign e_berr = e_wait == 6'(`GLUE_TIMEOUT);
	assign e_vec  = e_level == 3'd4 ? `GLUE_VEC_VBI : e_level == 3'd2 ? `GLUE_VEC_HBI : 8'h00;

	assert property (@(posedge clk_8) disable iff (!pll_locked) slot == e_slot)
		else begin
			errors++;
			$error("FAIL %0t slot got %0d expected %0d", $time, $sampled(slot), $sampled(e_slot));
		end

	assert property (@(posedge clk_8) disable iff (!pll_locked)
			{dtack_n, ram_oe_n, ram_we_n, berr} == {e_bus, e_berr})
		else begin
			errors++;
			$error("FAIL %0t dtack_n ram_oe_n ram_we_n berr got %b expected %b", $time,
				$sampled({dtack_n, ram_oe_n, ram_we_n, berr}), $sampled({e_bus, e_berr}));
		end

	assert property (@(posedge clk_8) disable iff (!pll_locked)
			{mmu_sel, vreg_sel, dma_sel, psg_sel, mfp_sel, acia_sel, mfp_iack} == e_sel)
		else begin
			errors++;
			$error("FAIL %0t selects got %b expected %b", $time, $sampled({mmu_sel, vreg_sel,
				dma_sel, psg_sel, mfp_sel, acia_sel, mfp_iack}), $sampled(e_sel));
		end

	assert property (@(posedge clk_8) disable iff (!pll_locked) ipl == e_ipl)
		else begin
			errors++;
			$error("FAIL %0t ipl got %b expected %b", $time, $sampled(ipl), $sampled(e_ipl));
		end

	assert property (@(posedge clk_8) disable iff (!pll_locked) vector == e_vec)
		else begin
			errors++;
			$error("FAIL %0t vector got %h expected %h", $time, $sampled(vector), $sampled(e_vec));
		end

endmodule

bind st_glue st_glue_properties props (.*);

// File: dv/st_glue_tb.sv
`include "glue_params.svh"

module st_glue_tb;

	logic                    clk_8 = 1'b0;
	logic                    pll_locked;
	logic [`GLUE_ADDR_W-1:0] addr;
	logic                    uds_n;
	logic                    lds_n;
	logic                    rw;
	bus_pkg::mem_cfg_e       mem_cfg;
	logic                    vs;
	logic                    hs;
	logic                    mfp_irq;
	bus_pkg::bus_slot_e      slot;
	logic                    ram_oe_n;
	logic                    ram_we_n;
	logic                    mmu_sel;
	logic                    vreg_sel;
	logic                    dma_sel;
	logic                    psg_sel;
	logic                    mfp_sel;
	logic                    acia_sel;
	logic                    mfp_iack;
	logic                    dtack_n;
	logic                    berr;
	irq_pkg::ipl_e           ipl;
	logic [`GLUE_DATA_W-1:0] vector;

	logic [31:0] lfsr = 32'h2feacfd4;
	int          tests;
	int          tests_failed;
	int          timeouts;
	int          err_base; // assertion failures before this test
	int          tmo_base;

	st_glue dut0 (.*);

	always #50 clk_8 = ~clk_8;

	// galois lfsr x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return v;
	endfunction

	// lands on a falling edge inside the cpu slot
	task automatic wait_cpu_slot();
		int n;
		n = 0;
		@(negedge clk_8);
		while (slot != bus_pkg::slot_cpu && n < 8) begin
			@(negedge clk_8);
			n++;
		end
		if (slot != bus_pkg::slot_cpu) begin
			$display("timeout: cpu slot did not come round at %0t", $time);
			timeouts++;
		end
	endtask

	// strobes low for one cpu slot, then wait for dtack if one is due
	task automatic bus_cycle(input logic [23:0] a, input logic read, input logic ack_due);
		int n;
		wait_cpu_slot();
		addr  = a[23:1];
		rw    = read;
		uds_n = 1'b0;
		lds_n = 1'b0;
		@(negedge clk_8);
		uds_n = 1'b1;
		lds_n = 1'b1;
		rw    = 1'b1;
		n     = 0;
		while (ack_due && dtack_n && n < 4) begin
			@(negedge clk_8);
			n++;
		end
		if (ack_due && dtack_n) begin
			$display("timeout: no dtack for address %h at %0t", a, $time);
			timeouts++;
		end
	endtask

	// random offset below base and random direction
	task automatic random_cycle(input logic [23:0] base, input int bits, input logic ack_due);
		logic [23:0] a;
		logic        rd;
		a  = base | 24'(rand_bits(bits));
		rd = rand_bits(1) != 0;
		bus_cycle(a, rd, ack_due);
	endtask

	task automatic wait_ipl(input irq_pkg::ipl_e lvl);
		int n;
		n = 0;
		while (ipl != lvl && n < 16) begin
			@(negedge clk_8);
			n++;
		end
		if (ipl != lvl) begin
			$display("timeout: ipl stayed %b while waiting for %b at %0t", ipl, lvl, $time);
			timeouts++;
		end
	endtask

	task automatic wait_berr(input logic level, input int limit);
		int n;
		n = 0;
		while (berr != level && n < limit) begin
			@(negedge clk_8);
			n++;
		end
		if (berr != level) begin
			$display("timeout: berr never went %b at %0t", level, $time);
			timeouts++;
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		int tmos;
		repeat (2) @(negedge clk_8); // last decode checked
		errs = dut0.props.errors - err_base;
		tmos = timeouts - tmo_base;
		tests++;
		if (errs == 0 && tmos == 0) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d assertion failures, %0d timeouts", tests, name, errs, tmos);
			tests_failed++;
		end
		err_base = dut0.props.errors;
		tmo_base = timeouts;
	endtask

	initial begin
		pll_locked   = 1'b0;
		addr         = '0;
		uds_n        = 1'b1;
		lds_n        = 1'b1;
		rw           = 1'b1;
		mem_cfg      = bus_pkg::mem_512k;
		vs           = 1'b0;
		hs           = 1'b0;
		mfp_irq      = 1'b0;
		tests        = 0;
		tests_failed = 0;
		timeouts     = 0;
		err_base     = 0;
		tmo_base     = 0;
		repeat (10) @(negedge clk_8);
		pll_locked = 1'b1;
		repeat (8) @(negedge clk_8); // two rotations, idle outputs
		end_test("reset and slot rotation");

		for (int c = 0; c < 6; c++) begin
			mem_cfg = bus_pkg::mem_cfg_e'(c);
			random_cycle(24'h000000, 22, 1'b1);
			random_cycle(24'h400000, 22, mem_cfg == bus_pkg::mem_8m || mem_cfg == bus_pkg::mem_14m);
			random_cycle(24'h800000, 22, mem_cfg == bus_pkg::mem_14m);
		end
		bus_cycle(24'he00000 | 24'(rand_bits(18)), 1'b0, 1'b0); // rom write, ignored
		bus_cycle(24'he00000 | 24'(rand_bits(18)), 1'b1, 1'b1);
		bus_cycle(24'hfa0000 | 24'(rand_bits(17)), 1'b1, 1'b1); // cartridge
		bus_cycle(24'hfc0000 | 24'(rand_bits(16)), 1'b1, 1'b1);
		end_test("ram and rom decode");

		random_cycle({8'hff, `GLUE_MMU_BASE}, 1, 1'b1);
		random_cycle({8'hff, `GLUE_VREG_BASE}, 7, 1'b1);
		random_cycle({8'hff, `GLUE_DMA_BASE}, 4, 1'b1);
		random_cycle({8'hff, `GLUE_PSG_BASE}, 2, 1'b1);
		random_cycle({8'hff, `GLUE_MFP_BASE}, 6, 1'b1);
		random_cycle({8'hff, `GLUE_ACIA_BASE}, 3, 1'b1);
		random_cycle(24'hff9000, 8, 1'b0); // hole in the io page
		end_test("io window selects");

		wait_cpu_slot();
		addr  = 23'h7fc800; // $ff9000, nothing there
		uds_n = 1'b0;
		lds_n = 1'b0;
		wait_berr(1'b1, 100);
		uds_n = 1'b1;
		lds_n = 1'b1;
		wait_berr(1'b0, 4);
		end_test("bus error timeout");

		vs = 1'b1;
		wait_ipl(irq_pkg::ipl_vbi);
		vs = 1'b0;
		bus_cycle(24'hfffff8, 1'b1, 1'b1); // level 4 iack
		wait_ipl(irq_pkg::ipl_none);
		end_test("vbi and level 4 iack");

		hs = 1'b1;
		wait_ipl(irq_pkg::ipl_hbi);
		hs = 1'b0;
		bus_cycle(24'hfffff4, 1'b1, 1'b1); // level 2
		wait_ipl(irq_pkg::ipl_none);
		vs = 1'b1;
		hs = 1'b1;
		wait_ipl(irq_pkg::ipl_vbi); // vbi over hbi
		mfp_irq = 1'b1;
		wait_ipl(irq_pkg::ipl_mfp);
		vs = 1'b0;
		hs = 1'b0;
		bus_cycle(24'hfffffc, 1'b1, 1'b1); // level 6, mfp_iack pulse
		mfp_irq = 1'b0;
		wait_ipl(irq_pkg::ipl_vbi);
		bus_cycle(24'hfffff8, 1'b1, 1'b1);
		wait_ipl(irq_pkg::ipl_hbi);
		bus_cycle(24'hfffff4, 1'b1, 1'b1);
		wait_ipl(irq_pkg::ipl_none);
		end_test("hbi, mfp priority and level 6 iack");

		$display("%0d tests, %0d failed, %0d assertion failures, %0d timeouts",
			tests, tests_failed, dut0.props.errors, timeouts);
		if (tests_failed == 0 && dut0.props.errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/irq_pkg.sv
verilog/bus_slot.sv
verilog/addr_decode.sv
verilog/bus_ack.sv
verilog/irq_ctrl.sv
verilog/st_glue.sv
dv/st_glue_properties.sv
dv/st_glue_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module st_glue_tb -f verilog.f -o Vst_glue_tb

./obj_dir/Vst_glue_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
